/* hdl/cache_pkg.sv */
package cache_pkg;

    // request opcodes, loads first then stores
    typedef enum logic [2:0] {
        op_load_byte,
        op_load_half,
        op_load_word,
        op_store_byte,
        op_store_half,
        op_store_word
    } access_op_e;

    // controller sequencing
    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_refill,
        st_respond
    } cache_state_e;

    typedef logic [31:0] word_t;

    // one bit per byte lane of word_t
    typedef logic [3:0] byte_en_t;

endpackage

/* hdl/mem_pkg.sv */
package mem_pkg;

    // 4 KiB byte address space
    typedef logic [11:0] byte_addr_t;

    // word address into the backing memory
    typedef logic [9:0] mem_addr_t;

    // word position within a cache line
    typedef logic [1:0] beat_t;

endpackage

/* hdl/req_queue.sv */
module req_queue #(
    parameter int req_credits = 2
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  push,
    input  cache_pkg::access_op_e push_op,
    input  mem_pkg::byte_addr_t   push_addr,
    input  cache_pkg::word_t      push_wdata,
    input  logic                  pop,
    output logic                  not_empty,
    output cache_pkg::access_op_e head_op,
    output mem_pkg::byte_addr_t   head_addr,
    output cache_pkg::word_t      head_wdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int ptr_w = (req_credits > 1) ? $clog2(req_credits) : 1;
    localparam int cnt_w = $clog2(req_credits + 1);

    access_op_e       op_q    [req_credits];
    byte_addr_t       addr_q  [req_credits];
    word_t            wdata_q [req_credits];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;

    // wrap at the credit count, which need not be a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(req_credits - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign not_empty  = (count != '0);
    assign head_op    = op_q[rd_ptr];
    assign head_addr  = addr_q[rd_ptr];
    assign head_wdata = wdata_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            op_q[wr_ptr]    <= push_op;
            addr_q[wr_ptr]  <= push_addr;
            wdata_q[wr_ptr] <= push_wdata;
        end
    end

    // credits bound the occupancy, so no full check
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + cnt_w'(push) - cnt_w'(pop);
        end
    end

endmodule

/* hdl/cache_ctrl.sv */
module cache_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  not_empty,
    input  cache_pkg::access_op_e head_op,
    input  mem_pkg::byte_addr_t   head_addr,
    input  cache_pkg::word_t      head_wdata,
    output logic                  pop,
    input  logic                  hit,
    input  logic                  refill_done,
    output logic                  refill_start,
    output logic                  lookup_en,
    output cache_pkg::access_op_e cur_op,
    output mem_pkg::byte_addr_t   cur_addr,
    output cache_pkg::word_t      cur_wdata,
    output logic                  mem_we,
    output logic                  resp_valid,
    output logic                  resp_hit,
    input  cache_pkg::word_t      load_data,
    output cache_pkg::word_t      resp_rdata
);
    import cache_pkg::*;

    cache_state_e state;
    cache_state_e state_next;
    logic         is_store;
    logic         missed;
    logic         resp_load;

    assign is_store = cur_op inside {op_store_byte, op_store_half, op_store_word};
    assign pop      = (state == st_idle) && not_empty;

    // store hit merges into the line while the same store writes through
    assign lookup_en    = (state == st_lookup) && hit && is_store;
    assign mem_we       = (state == st_lookup) && is_store;
    assign refill_start = (state == st_lookup) && !hit && !is_store;

    // data store captures the load field on the edge leaving lookup
    assign resp_rdata = resp_load ? load_data : '0;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (pop) begin
                    state_next = st_lookup;
                end
            end
            st_lookup: begin
                state_next = refill_start ? st_refill : st_respond;
            end
            st_refill: begin
                // back to lookup, which now hits the installed line
                if (refill_done) begin
                    state_next = st_lookup;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_op    <= head_op;
            cur_addr  <= head_addr;
            cur_wdata <= head_wdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state      <= st_idle;
            missed     <= 1'b0;
            resp_valid <= 1'b0;
            resp_hit   <= 1'b0;
            resp_load  <= 1'b0;
        end else begin
            state      <= state_next;
            resp_valid <= 1'b0;
            if (pop) begin
                missed <= 1'b0;
            end
            if (refill_start) begin
                missed <= 1'b1;
            end
            if ((state == st_lookup) && !refill_start) begin
                resp_valid <= 1'b1;
                // a refilled load reports its original miss
                resp_hit   <= hit && !missed;
                resp_load  <= !is_store;
            end
        end
    end

endmodule

/* hdl/refill_counter.sv */
module refill_counter #(
    parameter int line_words = 4
) (
    input  logic               clk,
    input  logic               rstn,
    input  logic               refill_start,
    input  mem_pkg::mem_addr_t line_base,
    output logic               mem_rd,
    output mem_pkg::mem_addr_t mem_raddr,
    input  logic               mem_rvalid,
    output mem_pkg::beat_t     beat,
    output logic               beat_valid,
    output logic               refill_done
);
    import mem_pkg::*;

    localparam int    beat_w    = $bits(beat_t);
    localparam beat_t last_beat = beat_t'(line_words - 1);

    logic  issuing;
    logic  busy;
    beat_t issue_beat;
    beat_t ret_beat;

    assign mem_rd = issuing;
    // line start plus the beat being requested
    assign mem_raddr  = {line_base[$bits(mem_addr_t)-1:beat_w], issue_beat};
    assign beat       = ret_beat;
    assign beat_valid = busy && mem_rvalid;

    // requests and returns tracked apart, any latency works
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            issuing     <= 1'b0;
            busy        <= 1'b0;
            issue_beat  <= '0;
            ret_beat    <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (refill_start) begin
                issuing    <= 1'b1;
                busy       <= 1'b1;
                issue_beat <= '0;
                ret_beat   <= '0;
            end else begin
                if (issuing) begin
                    issue_beat <= issue_beat + 1'b1;
                    if (issue_beat == last_beat) begin
                        issuing <= 1'b0;
                    end
                end
                if (beat_valid) begin
                    ret_beat <= ret_beat + 1'b1;
                    if (ret_beat == last_beat) begin
                        busy        <= 1'b0;
                        refill_done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* hdl/cache_tag_store.sv */
module cache_tag_store #(
    parameter int num_sets   = 8,
    parameter int num_ways   = 4,
    parameter int line_words = 4
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  mem_pkg::byte_addr_t         lookup_addr,
    output logic                        hit,
    output logic [$clog2(num_ways)-1:0] hit_way,
    output logic [$clog2(num_ways)-1:0] victim_way,
    input  logic                        install,
    input  logic [$clog2(num_ways)-1:0] install_way
);
    import mem_pkg::*;

    localparam int way_w = $clog2(num_ways);
    localparam int set_w = $clog2(num_sets);
    localparam int off_w = $clog2(line_words) + 2;
    localparam int tag_w = $bits(byte_addr_t) - set_w - off_w;

    logic [num_ways-1:0] valid  [num_sets];
    logic [tag_w-1:0]    tags   [num_sets][num_ways];
    logic [way_w-1:0]    rr_ptr [num_sets];
    logic [set_w-1:0]    set;
    logic [tag_w-1:0]    tag;
    logic                free_found;

    assign set = lookup_addr[off_w +: set_w];
    assign tag = lookup_addr[off_w + set_w +: tag_w];

    // every way of the set compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (valid[set][w] && (tags[set][w] == tag)) begin
                hit     = 1'b1;
                hit_way = way_w'(w);
            end
        end
    end

    // lowest invalid way wins, else round-robin
    always_comb begin
        free_found = 1'b0;
        victim_way = rr_ptr[set];
        for (int w = 0; w < num_ways; w++) begin
            if (!valid[set][w] && !free_found) begin
                free_found = 1'b1;
                victim_way = way_w'(w);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (install) begin
            tags[set][install_way] <= tag;
        end
    end

    // pointer moves on every refill of the set
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid[s]  <= '0;
                rr_ptr[s] <= '0;
            end
        end else if (install) begin
            valid[set][install_way] <= 1'b1;
            rr_ptr[set]             <= rr_ptr[set] + 1'b1;
        end
    end

endmodule

/* hdl/cache_data_store.sv */
module cache_data_store #(
    parameter int num_sets   = 8,
    parameter int num_ways   = 4,
    parameter int line_words = 4
) (
    input  logic                        clk,
    input  logic                        rstn,
    input  mem_pkg::byte_addr_t         addr,
    input  cache_pkg::access_op_e       op,
    input  cache_pkg::word_t            wdata,
    input  logic [$clog2(num_ways)-1:0] hit_way,
    input  logic                        store_hit,
    input  logic [$clog2(num_ways)-1:0] refill_way,
    input  mem_pkg::beat_t              beat,
    input  logic                        beat_valid,
    input  cache_pkg::word_t            refill_word,
    output cache_pkg::byte_en_t         wr_be,
    output cache_pkg::word_t            wr_data,
    output cache_pkg::word_t            load_data
);
    import cache_pkg::*;

    localparam int way_w  = $clog2(num_ways);
    localparam int set_w  = $clog2(num_sets);
    localparam int word_w = $clog2(line_words);
    localparam int idx_w  = way_w + set_w + word_w;

    word_t            lines [num_ways * num_sets * line_words];
    logic [set_w-1:0] set;
    logic [idx_w-1:0] hit_idx;
    logic [idx_w-1:0] fill_idx;
    logic [1:0]       lane;
    byte_en_t         size_mask;
    word_t            cur_word;
    word_t            field;

    // byte enables widened to a bit mask
    function automatic word_t lane_mask(input byte_en_t en);
        word_t mask;
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            mask[8*b +: 8] = {8{en[b]}};
        end
        return mask;
    endfunction

    assign set      = addr[word_w + 2 +: set_w];
    assign hit_idx  = {hit_way, set, addr[2 +: word_w]};
    assign fill_idx = {refill_way, set, beat[word_w-1:0]};
    assign cur_word = lines[hit_idx];

    // address bits below the access size are dropped here
    always_comb begin
        case (op)
            op_load_byte, op_store_byte: begin
                lane      = addr[1:0];
                size_mask = 4'b0001;
            end
            op_load_half, op_store_half: begin
                lane      = {addr[1], 1'b0};
                size_mask = 4'b0011;
            end
            default: begin
                lane      = 2'b00;
                size_mask = 4'b1111;
            end
        endcase
    end

    assign wr_be   = size_mask << lane;
    assign wr_data = wdata << {lane, 3'b000};
    assign field   = cur_word >> {lane, 3'b000};

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            lines[fill_idx] <= refill_word;
        end else if (store_hit) begin
            lines[hit_idx] <= (cur_word & ~lane_mask(wr_be)) | (wr_data & lane_mask(wr_be));
        end
    end

    // zero-extended load field, sampled every cycle
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_data <= '0;
        end else begin
            load_data <= field & lane_mask(size_mask);
        end
    end

endmodule

/* hdl/backing_mem.sv */
module backing_mem #(
    parameter int mem_latency = 3
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                we,
    input  mem_pkg::mem_addr_t  waddr,
    input  cache_pkg::word_t    wdata,
    input  cache_pkg::byte_en_t be,
    input  logic                rd,
    input  mem_pkg::mem_addr_t  raddr,
    output logic                rvalid,
    output cache_pkg::word_t    rdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int words = 2 ** $bits(mem_addr_t);

    word_t                  mem [words];
    logic [mem_latency-1:0] vld_pipe;
    word_t                  data_pipe [mem_latency];

    assign rvalid = vld_pipe[mem_latency-1];
    assign rdata  = data_pipe[mem_latency-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < words; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            for (int b = 0; b < $bits(byte_en_t); b++) begin
                if (be[b]) begin
                    mem[waddr][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    // one stage per cycle of latency, several reads in flight
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe[0] <= rd;
            for (int i = 1; i < mem_latency; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[raddr];
        for (int i = 1; i < mem_latency; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

endmodule

/* hdl/dcache_top.sv */
module dcache_top #(
    parameter int num_sets    = 8,
    parameter int num_ways    = 4,
    parameter int line_words  = 4,
    parameter int mem_latency = 3,
    parameter int req_credits = 2
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_valid,
    input  cache_pkg::access_op_e req_op,
    input  mem_pkg::byte_addr_t   req_addr,
    input  cache_pkg::word_t      req_wdata,
    output logic                  credit_return,
    output logic                  resp_valid,
    output logic                  resp_hit,
    output cache_pkg::word_t      resp_rdata
);
    import cache_pkg::*;
    import mem_pkg::*;

    localparam int way_w = $clog2(num_ways);

    logic             not_empty;
    access_op_e       head_op;
    byte_addr_t       head_addr;
    word_t            head_wdata;
    access_op_e       cur_op;
    byte_addr_t       cur_addr;
    word_t            cur_wdata;
    logic             hit;
    logic [way_w-1:0] hit_way;
    logic [way_w-1:0] victim_way;
    logic             lookup_en;
    logic             refill_start;
    logic             refill_done;
    logic             mem_we;
    logic             mem_rd;
    mem_addr_t        mem_raddr;
    logic             mem_rvalid;
    word_t            mem_rdata;
    beat_t            beat;
    logic             beat_valid;
    byte_en_t         wr_be;
    word_t            wr_data;
    word_t            load_data;

    // each pop hands a credit back to the requester
    req_queue #(.req_credits(req_credits)) req_queue_inst (
        .clk, .rstn,
        .push(req_valid), .push_op(req_op), .push_addr(req_addr), .push_wdata(req_wdata),
        .pop(credit_return), .not_empty,
        .head_op, .head_addr, .head_wdata
    );

    cache_ctrl cache_ctrl_inst (
        .clk, .rstn,
        .not_empty, .head_op, .head_addr, .head_wdata,
        .pop(credit_return), .hit, .refill_done, .refill_start, .lookup_en,
        .cur_op, .cur_addr, .cur_wdata, .mem_we,
        .resp_valid, .resp_hit, .load_data, .resp_rdata
    );

    refill_counter #(.line_words(line_words)) refill_counter_inst (
        .clk, .rstn,
        .refill_start, .line_base(cur_addr[11:2]),
        .mem_rd, .mem_raddr, .mem_rvalid,
        .beat, .beat_valid, .refill_done
    );

    cache_tag_store #(
        .num_sets(num_sets), .num_ways(num_ways), .line_words(line_words)
    ) cache_tag_store_inst (
        .clk, .rstn,
        .lookup_addr(cur_addr), .hit, .hit_way, .victim_way,
        .install(refill_done), .install_way(victim_way)
    );

    cache_data_store #(
        .num_sets(num_sets), .num_ways(num_ways), .line_words(line_words)
    ) cache_data_store_inst (
        .clk, .rstn,
        .addr(cur_addr), .op(cur_op), .wdata(cur_wdata),
        .hit_way, .store_hit(lookup_en),
        .refill_way(victim_way), .beat, .beat_valid, .refill_word(mem_rdata),
        .wr_be, .wr_data, .load_data
    );

    // every store writes through, hit or miss
    backing_mem #(.mem_latency(mem_latency)) backing_mem_inst (
        .clk, .rstn,
        .we(mem_we), .waddr(cur_addr[11:2]), .wdata(wr_data), .be(wr_be),
        .rd(mem_rd), .raddr(mem_raddr), .rvalid(mem_rvalid), .rdata(mem_rdata)
    );

endmodule

/* bench/dcache_properties.sv */
module dcache_properties (
    input logic                    clk,
    input logic                    rstn,
    input cache_pkg::cache_state_e state,
    input logic                    pop,
    input logic                    resp_valid,
    input logic                    refill_done
);
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;

    logic in_service;

    // set by a pop, cleared once its response has gone out
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            in_service <= 1'b0;
        end else if (pop) begin
            in_service <= 1'b1;
        end else if (resp_valid) begin
            in_service <= 1'b0;
        end
    end

    pop_one_at_a_time: assert property (@(posedge clk) disable iff (!rstn)
        pop |-> !in_service)
        else $error("pop while an earlier request is still in service");

    // single-cycle response pulse
    resp_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        resp_valid |=> !resp_valid)
        else $error("resp_valid held for more than one cycle");

    quiet_after_reset: assert property (@(posedge clk) $rose(rstn) |-> !resp_valid && !pop)
        else $error("response or credit return right after reset");

    refill_exit: assert property (@(posedge clk) disable iff (!rstn)
        (state == st_refill) && !refill_done |=> state == st_refill)
        else $error("refill state left without refill_done");

endmodule

bind cache_ctrl dcache_properties dcache_properties_inst (
    .clk, .rstn, .state, .pop, .resp_valid, .refill_done
);

/* bench/dcache_tb.sv */
module dcache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import cache_pkg::*;
    import mem_pkg::*;

    localparam int num_sets     = 8;
    localparam int num_ways     = 4;
    localparam int line_words   = 4;
    localparam int mem_latency  = 3;
    localparam int req_credits  = 2;
    localparam int num_random   = 400;
    // upper bound on the directed requests below
    localparam int num_directed = 40;
    // pop, lookup, refill beats, memory latency, second lookup, respond, idle
    localparam int worst_cycles = line_words + mem_latency + 8;
    localparam int timeout_ns   = ((num_random + num_directed) * worst_cycles + 100) * 20;

    logic       clk = 1'b0;
    logic       rstn;
    logic       req_valid;
    access_op_e req_op;
    byte_addr_t req_addr;
    word_t      req_wdata;
    logic       credit_return;
    logic       resp_valid;
    logic       resp_hit;
    word_t      resp_rdata;

    integer seed    = 32'h1a36;
    int     credits = req_credits;

    // requests waiting for a credit
    access_op_e pend_op[$];
    byte_addr_t pend_addr[$];
    word_t      pend_wdata[$];
    logic       exp_hit[$];
    word_t      exp_data[$];

    // reference state, memory and tags
    word_t               model_mem [1024];
    logic [num_ways-1:0] model_valid [num_sets];
    int                  model_tag [num_sets][num_ways];
    int                  model_rr [num_sets];

    dcache_top #(
        .num_sets(num_sets), .num_ways(num_ways), .line_words(line_words),
        .mem_latency(mem_latency), .req_credits(req_credits)
    ) dcache_top_inst (
        .clk, .rstn,
        .req_valid, .req_op, .req_addr, .req_wdata,
        .credit_return, .resp_valid, .resp_hit, .resp_rdata
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    // expected hit flag and load value, updates the model as the cache would
    function automatic void predict(input access_op_e op, input byte_addr_t addr,
                                    input word_t wdata, output logic hit, output word_t data);
        int    s;
        int    t;
        int    shift;
        int    victim;
        word_t mask;
        s = (int'(addr) / (4 * line_words)) % num_sets;
        t = int'(addr) / (4 * line_words * num_sets);
        hit = 1'b0;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[s][w] && model_tag[s][w] == t) begin
                hit = 1'b1;
            end
        end
        case (op)
            op_load_byte, op_store_byte: begin
                mask  = 32'h0000_00ff;
                shift = 8 * int'(addr[1:0]);
            end
            op_load_half, op_store_half: begin
                mask  = 32'h0000_ffff;
                shift = 16 * int'(addr[1]);
            end
            default: begin
                mask  = 32'hffff_ffff;
                shift = 0;
            end
        endcase
        if (op inside {op_load_byte, op_load_half, op_load_word}) begin
            data = (model_mem[addr[11:2]] >> shift) & mask;
            if (!hit) begin
                // lowest invalid way, else the set's round-robin pointer
                victim = model_rr[s];
                for (int w = num_ways - 1; w >= 0; w--) begin
                    if (!model_valid[s][w]) begin
                        victim = w;
                    end
                end
                model_valid[s][victim] = 1'b1;
                model_tag[s][victim]   = t;
                model_rr[s]            = (model_rr[s] + 1) % num_ways;
            end
        end else begin
            data = '0;
            model_mem[addr[11:2]] = (model_mem[addr[11:2]] & ~(mask << shift))
                                  | ((wdata & mask) << shift);
        end
    endfunction

    task automatic queue_req(input access_op_e op, input byte_addr_t addr, input word_t wdata);
        pend_op.push_back(op);
        pend_addr.push_back(addr);
        pend_wdata.push_back(wdata);
    endtask

    task automatic drain();
        while (pend_op.size() != 0 || exp_hit.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // one request per credit, predicted as it leaves
    always @(posedge clk) begin
        logic  hit;
        word_t data;
        if (!rstn) begin
            req_valid <= 1'b0;
        end else begin
            if (credit_return) begin
                credits++;
            end
            if (credits > 0 && pend_op.size() != 0) begin
                predict(pend_op[0], pend_addr[0], pend_wdata[0], hit, data);
                exp_hit.push_back(hit);
                exp_data.push_back(data);
                req_valid <= 1'b1;
                req_op    <= pend_op.pop_front();
                req_addr  <= pend_addr.pop_front();
                req_wdata <= pend_wdata.pop_front();
                credits--;
            end else begin
                req_valid <= 1'b0;
            end
            if (credits < 0 || credits > req_credits) begin
                abort_run($sformatf("credit count left its range 0..%0d: %0d",
                                    req_credits, credits));
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && resp_valid) begin
            if (exp_hit.size() == 0) begin
                abort_run("a response arrived with no request outstanding");
            end else begin
                check_word("resp_rdata", resp_rdata, exp_data.pop_front());
                check_bit("resp_hit", resp_hit, exp_hit.pop_front());
            end
        end
    end

    initial begin
        #(timeout_ns);
        abort_run("watchdog timeout, responses stopped arriving");
    end

    initial begin
        word_t r;
        word_t a;
        word_t d;
        rstn      = 1'b0;
        req_valid = 1'b0;
        req_op    = op_load_word;
        req_addr  = '0;
        req_wdata = '0;
        for (int i = 0; i < 1024; i++) begin
            model_mem[i] = '0;
        end
        for (int s = 0; s < num_sets; s++) begin
            model_valid[s] = '0;
            model_rr[s]    = 0;
        end
        repeat (5) @(posedge clk);
        rstn <= 1'b1;

        // cold miss, then a warm hit in the same line
        queue_req(op_store_word, 12'h10c, 32'hcafe_0123);
        queue_req(op_load_word, 12'h104, '0);
        queue_req(op_load_word, 12'h10c, '0);
        drain();

        // store miss, refill sees it, then sized merges and loads
        queue_req(op_store_word, 12'h208, 32'hdead_beef);
        queue_req(op_load_word, 12'h208, '0);
        queue_req(op_load_word, 12'h20c, '0);
        queue_req(op_store_byte, 12'h209, 32'h0000_00a5);
        queue_req(op_store_half, 12'h20f, 32'h0000_1234);
        queue_req(op_load_byte, 12'h20b, '0);
        queue_req(op_load_half, 12'h209, '0);
        queue_req(op_load_half, 12'h20f, '0);
        queue_req(op_load_word, 12'h20a, '0);
        queue_req(op_load_byte, 12'h208, '0);
        drain();

        // five lines in set 5, then revisit under round-robin
        for (int t = 0; t < 5; t++) begin
            queue_req(op_load_word, byte_addr_t'(t * 12'h80 + 12'h050), '0);
        end
        queue_req(op_load_word, 12'h0d0, '0);
        queue_req(op_load_word, 12'h050, '0);
        queue_req(op_load_word, 12'h250, '0);
        queue_req(op_load_word, 12'h0d0, '0);
        drain();

        // burst that uses every credit
        queue_req(op_store_half, 12'h302, 32'h0000_beef);
        queue_req(op_load_half, 12'h302, '0);
        queue_req(op_load_word, 12'h300, '0);
        queue_req(op_store_byte, 12'h301, 32'h0000_0077);
        queue_req(op_load_word, 12'h300, '0);
        queue_req(op_load_byte, 12'h303, '0);
        drain();

        for (int i = 0; i < num_random; i++) begin
            r = $random(seed);
            a = $random(seed);
            d = $random(seed);
            queue_req(access_op_e'(3'(r % 6)), byte_addr_t'(a), d);
        end
        drain();

        if (credits == req_credits && exp_hit.size() == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run($sformatf("run ended with %0d credits and %0d missing responses",
                                credits, exp_hit.size()));
        end
    end

endmodule

/* flist.f */
hdl/cache_pkg.sv
hdl/mem_pkg.sv
hdl/req_queue.sv
hdl/cache_ctrl.sv
hdl/refill_counter.sv
hdl/cache_tag_store.sv
hdl/cache_data_store.sv
hdl/backing_mem.sv
hdl/dcache_top.sv
bench/dcache_properties.sv
bench/dcache_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the dcache testbench, exit status is the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module dcache_tb -f flist.f -o dcache_sim \
    && ./obj_dir/dcache_sim \
    || exit 1
